// ==== rtl/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and instruction width
`define WORD_WIDTH 32

// Boot vector, first address fetched after reset
`define RESET_PC 32'hBFC0_0000

// All-zero word, doubles as the NOP encoding (SLL r0, r0, 0)
`define ZERO_WORD 32'h0000_0000

// Register file geometry
`define REG_ADDR_WIDTH 5
`define REG_COUNT 32

// Implicit return address register for JAL, BLTZAL, BGEZAL
`define LINK_REG 5'd31

`endif

// ==== rtl/cpu_pkg.sv ====
`include "cpu_defines.svh"

package cpu_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t; // Register data
	typedef logic [`WORD_WIDTH-1:0] inst_t; // Raw instruction word
	typedef logic [`WORD_WIDTH-1:0] inst_addr_t; // Byte address
	typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

	// Primary opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000, // JR, JALR via funct
		OP_REGIMM  = 6'b000001, // Sign branches via rt
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111
	} opcode_e;

	// REGIMM sub-opcode carried in the rt field, inst[20:16]
	// Bit 0 selects GEZ over LTZ, bit 4 selects the linking form
	typedef enum logic [4:0] {
		RT_BLTZ   = 5'b00000,
		RT_BGEZ   = 5'b00001,
		RT_BLTZAL = 5'b10000,
		RT_BGEZAL = 5'b10001
	} regimm_e;

	// SPECIAL funct field, inst[5:0]
	typedef enum logic [5:0] {
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001
	} funct_e;

endpackage

// ==== rtl/reg_file.sv ====
`include "cpu_defines.svh"

module reg_file import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst,

	// Two read ports for rs and rt
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,

	// Return address write from decode
	input  logic      link_en,
	input  reg_addr_t link_addr,
	input  word_t     link_data,

	// Preload port from outside
	input  logic      wr_en,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	word_t regs [`REG_COUNT];

	// Reads are combinational, no write-to-read bypass
	// Entry 0 is never written so it stays zero from reset
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= `ZERO_WORD;
			end
		end else begin
			if (wr_en && (wr_addr != '0)) begin // Preload, r0 stays hardwired
				regs[wr_addr] <= wr_data;
			end
			// Issued after the preload so the link value wins on a clash
			if (link_en && (link_addr != '0)) begin
				regs[link_addr] <= link_data;
			end
		end
	end

endmodule

// ==== rtl/branch_unit.sv ====
`include "cpu_defines.svh"

module branch_unit import cpu_pkg::*; (
	input  inst_addr_t pc, // Address of the instruction in decode
	input  inst_t      inst,
	input  word_t      reg1, // Value of rs
	input  word_t      reg2, // Value of rt

	output logic       is_branch,
	output logic       jump,
	output inst_addr_t jump_to,
	output logic       is_link // Writes a return address
);

	opcode_e     opcode;
	regimm_e     rt_code;
	funct_e      funct;
	logic [25:0] instr_index;
	logic [15:0] offset;

	inst_addr_t  pc_plus4;
	inst_addr_t  target_i; // Relative branch target
	inst_addr_t  target_j; // Region jump target
	logic        reg_equal;

	assign opcode      = opcode_e'(inst[31:26]);
	assign rt_code     = regimm_e'(inst[20:16]);
	assign funct       = funct_e'(inst[5:0]);
	assign instr_index = inst[25:0];
	assign offset      = inst[15:0];

	assign pc_plus4  = pc + 32'd4;
	assign target_i  = pc_plus4 + {{14{offset[15]}}, offset, 2'b00}; // Offset in words
	assign target_j  = {pc_plus4[31:28], instr_index, 2'b00}; // Stays in the 256 MB region

	// Shared by all four compare branches
	assign reg_equal = (reg1 == reg2);

	always_comb begin
		is_branch = 1'b1;
		jump      = 1'b0;
		jump_to   = target_i;
		is_link   = 1'b0;
		unique case (opcode)
			OP_REGIMM: begin
				unique case (rt_code)
					RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL: begin
						// Sign bit alone decides, rt bit 0 flips LTZ into GEZ
						jump    = reg1[31] ^ rt_code[0];
						is_link = rt_code[4]; // AL forms link even when not taken
					end
					default: begin // Undefined rt, treat as plain instruction
						is_branch = 1'b0;
						jump_to   = `ZERO_WORD;
					end
				endcase
			end
			// BEQ/BNE use the equality, BLEZ/BGTZ add the sign of rs
			// For BLEZ/BGTZ the rt field is r0, so reg_equal means rs is zero
			// Opcode bit 0 inverts the sense for BNE and BGTZ
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
				jump = ((reg1[31] & opcode[1]) | reg_equal) ^ opcode[0];
			OP_J, OP_JAL: begin
				jump    = 1'b1;
				jump_to = target_j;
				is_link = (opcode == OP_JAL);
			end
			OP_SPECIAL: begin
				unique case (funct)
					FN_JR, FN_JALR: begin
						jump    = 1'b1;
						jump_to = reg1; // Target taken as is, alignment unchecked
						is_link = (funct == FN_JALR);
					end
					default: begin // Other SPECIAL ops, NOP included
						is_branch = 1'b0;
						jump_to   = `ZERO_WORD;
					end
				endcase
			end
			default: begin
				is_branch = 1'b0;
				jump_to   = `ZERO_WORD;
			end
		endcase
	end

endmodule

// ==== rtl/decode_stage.sv ====
`include "cpu_defines.svh"

module decode_stage import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,

	// From fetch, same cycle as the memory answer
	input  inst_addr_t fetch_pc,
	input  inst_t      fetch_inst,

	// Redirect back to fetch
	output logic       jump,
	output inst_addr_t jump_to,

	// Return address write, also visible at the top
	output logic       link_en,
	output reg_addr_t  link_addr,
	output word_t      link_data,

	// Register preload
	input  logic       wr_en,
	input  reg_addr_t  wr_addr,
	input  word_t      wr_data
);

	inst_addr_t dec_pc;
	inst_t      dec_inst;
	word_t      rs_data;
	word_t      rt_data;
	logic       is_branch;
	logic       is_link;
	logic       is_jalr; // Link goes to rd instead of r31

	// Decode register, resets to a NOP so nothing branches or links
	always_ff @(posedge clk) begin
		if (rst) begin
			dec_pc   <= `ZERO_WORD;
			dec_inst <= `ZERO_WORD;
		end else begin
			dec_pc   <= fetch_pc;
			dec_inst <= fetch_inst;
		end
	end

	reg_file i_reg_file (
		.clk       (clk),
		.rst       (rst),
		.raddr1    (dec_inst[25:21]), // rs
		.raddr2    (dec_inst[20:16]), // rt
		.rdata1    (rs_data),
		.rdata2    (rt_data),
		.link_en   (link_en),
		.link_addr (link_addr),
		.link_data (link_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	branch_unit i_branch_unit (
		.pc        (dec_pc),
		.inst      (dec_inst),
		.reg1      (rs_data),
		.reg2      (rt_data),
		.is_branch (is_branch),
		.jump      (jump),
		.jump_to   (jump_to),
		.is_link   (is_link)
	);

	assign is_jalr   = (dec_inst[31:26] == OP_SPECIAL) && (dec_inst[5:0] == FN_JALR);
	assign link_en   = is_branch & is_link;
	assign link_addr = is_jalr ? dec_inst[15:11] : `LINK_REG;
	assign link_data = dec_pc + 32'd8; // Skips the delay slot

	// JALR must name a real rd, otherwise the return address is silently lost
	a_link_not_zero: assert property (@(posedge clk) disable iff (rst)
		link_en |-> (link_addr != '0))
		else $error("decode_stage: link write to r0");

endmodule

// ==== rtl/fetch_unit.sv ====
`include "cpu_defines.svh"

module fetch_unit import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       jump, // Taken branch in decode
	input  inst_addr_t jump_to,
	output inst_addr_t pc // Address sent to instruction memory
);

	inst_addr_t pc_next;

	// Redirect lands one cycle later, after the delay slot has been fetched
	assign pc_next = jump ? jump_to : (pc + 32'd4);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// Redirect target must be word aligned
	// Only a JR or JALR register value can break this
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		jump |-> (jump_to[1:0] == 2'b00))
		else $error("fetch_unit: redirect target not word aligned");

endmodule

// ==== rtl/branch_core_top.sv ====
`include "cpu_defines.svh"

module branch_core_top import cpu_pkg::*; (
	input  logic       clk,
	input  logic       rst,

	// Instruction memory, answers in the same cycle
	output inst_addr_t inst_addr,
	input  inst_t      inst_data,

	// Register preload
	input  logic       wr_en,
	input  reg_addr_t  wr_addr,
	input  word_t      wr_data,

	// Observation of the decode stage
	output logic       jump,
	output logic       link_en,
	output reg_addr_t  link_addr,
	output word_t      link_data
);

	inst_addr_t jump_to; // Decode back to fetch

	fetch_unit i_fetch_unit (
		.clk     (clk),
		.rst     (rst),
		.jump    (jump),
		.jump_to (jump_to),
		.pc      (inst_addr)
	);

	// The fetch address travels with its instruction into decode
	decode_stage i_decode_stage (
		.clk        (clk),
		.rst        (rst),
		.fetch_pc   (inst_addr),
		.fetch_inst (inst_data),
		.jump       (jump),
		.jump_to    (jump_to),
		.link_en    (link_en),
		.link_addr  (link_addr),
		.link_data  (link_data),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data)
	);

endmodule

// ==== test/tb_top.sv ====
`include "cpu_defines.svh"

module tb_top import cpu_pkg::*; ();

	localparam int MEM_WORDS = 64; // Program image from RESET_PC upward
	localparam int MAX_CYC   = 64;

	logic       clk;
	logic       rst;
	inst_addr_t inst_addr;
	inst_t      inst_data;
	logic       wr_en;
	reg_addr_t  wr_addr;
	word_t      wr_data;
	logic       jump;
	logic       link_en;
	reg_addr_t  link_addr;
	word_t      link_data;

	inst_t      imem [MEM_WORDS];
	word_t      mreg [32]; // Model register file
	logic       pl_en [MAX_CYC]; // Preload schedule by cycle after reset
	reg_addr_t  pl_addr [MAX_CYC];
	word_t      pl_data [MAX_CYC];
	inst_addr_t exp_addr [MAX_CYC]; // Predicted outputs per cycle
	logic       exp_jump [MAX_CYC];
	logic       exp_link [MAX_CYC];
	reg_addr_t  exp_laddr [MAX_CYC];
	word_t      exp_ldata [MAX_CYC];
	int         n_checks;
	int         n_errors;
	logic [31:0] rng;

	branch_core_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.inst_addr (inst_addr),
		.inst_data (inst_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.jump      (jump),
		.link_en   (link_en),
		.link_addr (link_addr),
		.link_data (link_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic inst_t mem_word(inst_addr_t addr);
		inst_addr_t off;
		off = addr - `RESET_PC;
		if (off[1:0] == 2'b00 && off < MEM_WORDS * 4) return imem[off[7:2]];
		return `ZERO_WORD; // NOP outside the loaded program
	endfunction

	always_comb inst_data = mem_word(inst_addr); // Memory answers in the same cycle

	function automatic inst_addr_t word_addr(int w);
		return `RESET_PC + (32'(w) << 2);
	endfunction

	function automatic inst_t enc_i(opcode_e op, reg_addr_t rs, reg_addr_t rt, int off);
		return {op, rs, rt, off[15:0]};
	endfunction

	function automatic inst_t enc_j(opcode_e op, inst_addr_t target);
		return {op, target[27:2]};
	endfunction

	function automatic inst_t enc_r(reg_addr_t rs, reg_addr_t rd, funct_e fn);
		return {OP_SPECIAL, rs, 5'd0, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] xorshift(logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// MIPS rules for the instruction sitting in decode
	function automatic void model_decide(input inst_addr_t pc, input inst_t inst,
		output logic take, output inst_addr_t target, output logic link,
		output reg_addr_t laddr);
		logic signed [31:0] a;
		logic signed [31:0] b;
		logic signed [31:0] soff;
		inst_addr_t pc4;
		a = mreg[inst[25:21]];
		b = mreg[inst[20:16]];
		soff = 32'($signed(inst[15:0]));
		pc4 = pc + 32'd4;
		take = 1'b0;
		target = pc4 + (soff <<< 2);
		link = 1'b0;
		laddr = `LINK_REG;
		case (inst[31:26])
			OP_BEQ:  take = (a == b);
			OP_BNE:  take = (a != b);
			OP_BLEZ: take = (a <= 0);
			OP_BGTZ: take = (a > 0);
			OP_REGIMM: begin
				case (inst[20:16])
					RT_BLTZ:   take = (a < 0);
					RT_BGEZ:   take = (a >= 0);
					RT_BLTZAL: begin
						take = (a < 0);
						link = 1'b1;
					end
					RT_BGEZAL: begin
						take = (a >= 0);
						link = 1'b1;
					end
					default: ; // Not a branch
				endcase
			end
			OP_J, OP_JAL: begin
				take = 1'b1;
				target = (pc4 & 32'hF000_0000) | (32'(inst[25:0]) << 2);
				link = (inst[31:26] == OP_JAL);
			end
			OP_SPECIAL: begin
				if (inst[5:0] == FN_JR || inst[5:0] == FN_JALR) begin
					take = 1'b1;
					target = mreg[inst[25:21]];
				end
				if (inst[5:0] == FN_JALR) begin
					link = 1'b1;
					laddr = inst[15:11]; // rd
				end
			end
			default: ;
		endcase
	endfunction

	// Walks the pipeline cycle by cycle from reset release
	task automatic build_trace(input int n);
		inst_addr_t pc;
		inst_addr_t dpc;
		inst_addr_t tgt;
		inst_t      dinst;
		logic       take;
		logic       lnk;
		reg_addr_t  la;
		for (int i = 0; i < 32; i++) mreg[i] = `ZERO_WORD;
		pc = `RESET_PC;
		dpc = `ZERO_WORD;
		dinst = `ZERO_WORD; // Decode starts as a NOP
		for (int k = 0; k < n; k++) begin
			model_decide(dpc, dinst, take, tgt, lnk, la);
			exp_addr[k] = pc;
			exp_jump[k] = take;
			exp_link[k] = lnk;
			exp_laddr[k] = la;
			exp_ldata[k] = dpc + 32'd8; // Return past the delay slot
			if (pl_en[k] && pl_addr[k] != 0) mreg[pl_addr[k]] = pl_data[k];
			if (lnk && la != 0) mreg[la] = dpc + 32'd8; // Link beats preload
			dpc = pc;
			dinst = mem_word(pc);
			pc = take ? tgt : pc + 32'd4;
		end
	endtask

	task automatic check_value(input string sig, input logic [31:0] got,
		input logic [31:0] expected);
		n_checks++;
		assert (got === expected) else begin
			$display("FAILED t=%0t %s expected %h got %h", $time, sig, expected, got);
			n_errors++;
		end
	endtask

	task automatic wait_for_addr(input inst_addr_t addr, input int limit);
		int n;
		n = 0;
		while (inst_addr !== addr && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		n_checks++;
		assert (inst_addr === addr) else begin
			$display("Timed out after %0d cycles waiting for fetch address %h", n, addr);
			n_errors++;
		end
	endtask

	task automatic clear_program();
		for (int i = 0; i < MEM_WORDS; i++) imem[i] = `ZERO_WORD;
		for (int k = 0; k < MAX_CYC; k++) begin
			pl_en[k] = 1'b0;
			pl_addr[k] = '0;
			pl_data[k] = `ZERO_WORD;
		end
	endtask

	task automatic preload(input int k, input reg_addr_t addr, input word_t data);
		pl_en[k] = 1'b1;
		pl_addr[k] = addr;
		pl_data[k] = data;
	endtask

	// Reset, then step n cycles comparing against the model
	task automatic run_trace(input int n);
		build_trace(n);
		rst = 1'b1;
		wr_en = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		wait_for_addr(`RESET_PC, 4);
		for (int k = 0; k < n; k++) begin
			wr_en = pl_en[k];
			wr_addr = pl_addr[k];
			wr_data = pl_data[k];
			@(negedge clk); // Outputs settled mid cycle
			check_value("inst_addr", inst_addr, exp_addr[k]);
			check_value("jump", 32'(jump), 32'(exp_jump[k]));
			check_value("link_en", 32'(link_en), 32'(exp_link[k]));
			if (exp_link[k]) begin
				check_value("link_addr", 32'(link_addr), 32'(exp_laddr[k]));
				check_value("link_data", link_data, exp_ldata[k]);
			end
			@(posedge clk);
			#1;
		end
		wr_en = 1'b0;
	endtask

	task automatic report_test(input string name, input int start);
		$display("Test %-20s %s, %0d errors", name, (n_errors == start) ? "ok" : "bad",
			n_errors - start);
	endtask

	task automatic test_reset_nops();
		int start;
		start = n_errors;
		clear_program();
		run_trace(12);
		report_test("reset_nops", start);
	endtask

	task automatic test_cond_branches();
		int start;
		start = n_errors;
		clear_program();
		preload(0, 5'd1, 32'd5);
		preload(1, 5'd2, 32'd5);
		preload(2, 5'd3, 32'd7);
		preload(3, 5'd4, 32'hFFFF_FFFD); // -3
		imem[16] = enc_i(OP_BEQ, 5'd1, 5'd2, 3); // Taken
		imem[20] = enc_i(OP_BNE, 5'd1, 5'd2, 5); // Not taken
		imem[22] = enc_i(OP_BNE, 5'd1, 5'd3, 2);
		imem[25] = enc_i(OP_BLEZ, 5'd4, 5'd0, 2); // Negative
		imem[28] = enc_i(OP_BLEZ, 5'd3, 5'd0, 5);
		imem[30] = enc_i(OP_BGTZ, 5'd6, 5'd0, 4); // Zero, not taken
		imem[32] = enc_i(OP_BGTZ, 5'd3, 5'd0, 3);
		imem[36] = enc_i(OP_BEQ, 5'd1, 5'd3, 4);
		imem[38] = enc_i(OP_BLEZ, 5'd6, 5'd0, 2); // Zero, taken
		imem[41] = enc_i(OP_BGTZ, 5'd4, 5'd0, 6);
		run_trace(40);
		report_test("cond_branches", start);
	endtask

	task automatic test_regimm();
		int start;
		start = n_errors;
		clear_program();
		preload(0, 5'd1, 32'hFFFF_FFF8);
		preload(1, 5'd2, 32'd9);
		imem[16] = enc_i(OP_REGIMM, 5'd1, RT_BLTZ, 2);
		imem[19] = enc_i(OP_REGIMM, 5'd1, RT_BGEZ, 4);
		imem[21] = enc_i(OP_REGIMM, 5'd2, RT_BLTZAL, 4); // Links though untaken
		imem[23] = enc_i(OP_REGIMM, 5'd2, RT_BGEZAL, 3);
		imem[27] = enc_i(OP_REGIMM, 5'd1, 5'b00011, 5); // Undefined rt
		imem[28] = enc_i(OP_REGIMM, 5'd31, RT_BLTZ, 3); // r31 holds the link
		run_trace(36);
		report_test("regimm", start);
	endtask

	task automatic test_jumps();
		int start;
		start = n_errors;
		clear_program();
		preload(0, 5'd5, word_addr(40));
		preload(1, 5'd6, word_addr(48));
		imem[16] = enc_j(OP_J, word_addr(20));
		imem[20] = enc_j(OP_JAL, word_addr(24));
		imem[24] = enc_r(5'd5, 5'd0, FN_JR);
		imem[40] = enc_r(5'd6, 5'd7, FN_JALR); // Return address into r7
		imem[48] = enc_r(5'd7, 5'd0, FN_JR);
		imem[44] = enc_r(5'd31, 5'd0, FN_JR); // Back to the JAL return
		run_trace(40);
		report_test("jumps", start);
	endtask

	task automatic test_link_clash();
		int start;
		start = n_errors;
		clear_program();
		imem[16] = enc_j(OP_JAL, word_addr(20)); // In decode at cycle 17
		preload(17, 5'd31, 32'h1234_5678);
		imem[20] = enc_r(5'd31, 5'd0, FN_JR);
		run_trace(30);
		report_test("link_clash", start);
	endtask

	task automatic test_random_branches();
		int start;
		int off;
		word_t v1;
		word_t v2;
		opcode_e op;
		start = n_errors;
		for (int r = 0; r < 20; r++) begin
			clear_program();
			rng = xorshift(rng);
			v1 = rng;
			rng = xorshift(rng);
			v2 = (r % 2 == 0) ? v1 : rng; // Every other round equal
			rng = xorshift(rng);
			op = rng[0] ? OP_BEQ : OP_BNE;
			off = int'(rng[15:8] % 8'd20) - 10; // Lands in words 7 to 26
			preload(0, 5'd1, v1);
			preload(1, 5'd2, v2);
			imem[16] = enc_i(op, 5'd1, 5'd2, off);
			run_trace(24);
		end
		report_test("random_branches", start);
	endtask

	initial begin
		rst = 1'b1;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = `ZERO_WORD;
		n_checks = 0;
		n_errors = 0;
		rng = 32'h1920;
		clear_program();
		test_reset_nops();
		test_cond_branches();
		test_regimm();
		test_jumps();
		test_link_clash();
		test_random_branches();
		$display("Summary: %0d checks, %0d passed, %0d failed", n_checks,
			n_checks - n_errors, n_errors);
		if (n_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/reg_file.sv
rtl/branch_unit.sv
rtl/decode_stage.sv
rtl/fetch_unit.sv
rtl/branch_core_top.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the branch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_top \
	--Mdir "$BUILD_DIR" -o tb_top_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_top_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	exit 1
fi
exit 0
